/* common/fpuPkg.sv */
`default_nettype none

package fpuPkg;

	// status codes on exOk, same encoding as the memory unit
	localparam logic [1:0] exOkReady = 2'd0;
	localparam logic [1:0] exOkHold = 2'd1;
	localparam logic [1:0] exOkOk = 2'd2;

	// binary64 field widths
	localparam int expWidth = 11;
	localparam int fraWidth = 52;
	// significand with hidden bit and one guard bit on top
	localparam int sigWidth = 54;
	localparam int expBias = 1023;

	// operation tag, zero means no request
	typedef logic [1:0] exOpT;

	// one double word, seen as raw bits or as its fields
	typedef union packed {
		logic [63:0] bits;
		struct packed {
			logic sign;
			logic [expWidth-1:0] exponent;
			logic [fraWidth-1:0] fraction;
		} field;
	} fpDouble;

endpackage

`default_nettype wire

/* common/fpuStageIf.sv */
`timescale 1ns/1ps
`default_nettype none

// unpacked operands, registered at edge 1
interface mulOperandIf;
	import fpuPkg::*;

	// exOp nonzero, not registered
	logic advance;
	logic sign;
	// biased exponent sum, two's complement, saturated at 2047
	logic [expWidth:0] expSum;
	logic [sigWidth-1:0] sigA;
	logic [sigWidth-1:0] sigB;
	// one operand had a zero exponent
	logic zero;
	exOpT tag;

	modport src (
		output advance,
		output sign,
		output expSum,
		output sigA,
		output sigB,
		output zero,
		output tag
	);

	modport dst (
		input advance,
		input sign,
		input expSum,
		input sigA,
		input sigB,
		input zero,
		input tag
	);

endinterface

// reduced partial product terms, registered at edge 3
interface mulSumIf;
	import fpuPkg::*;

	logic advance;
	logic sign;
	logic [expWidth:0] exponent;
	// bit k of either term has product weight k+44
	logic [63:0] termQ;
	logic [63:0] termR;
	logic zero;
	exOpT tag;

	modport src (
		output advance,
		output sign,
		output exponent,
		output termQ,
		output termR,
		output zero,
		output tag
	);

	modport dst (
		input advance,
		input sign,
		input exponent,
		input termQ,
		input termR,
		input zero,
		input tag
	);

endinterface

`default_nettype wire

/* fpuMul/csAdd64.sv */
`timescale 1ns/1ps
`default_nettype none

module csAdd64 (
	input logic [63:0] a,
	input logic [63:0] b,
	output logic [63:0] sum
);

	// carry into blocks 1..3
	logic [3:1] carry;
	logic [16:0] lowSum;

	// lowest block is a plain add, its carry starts the select chain
	assign lowSum = {1'b0, a[15:0]} + {1'b0, b[15:0]};
	assign sum[15:0] = lowSum[15:0];
	assign carry[1] = lowSum[16];

	genvar i;
	for (i = 1; i < 4; i++)
	begin : gBlock
		logic [16:0] sumNoCarry;
		logic [16:0] sumCarry;

		// both outcomes computed in parallel
		assign sumNoCarry = {1'b0, a[16*i +: 16]} + {1'b0, b[16*i +: 16]};
		assign sumCarry = {1'b0, a[16*i +: 16]} + {1'b0, b[16*i +: 16]} + 17'd1;

		// carry from below picks one
		assign sum[16*i +: 16] = carry[i] ? sumCarry[15:0] : sumNoCarry[15:0];

		// top block carry out is not needed
		if (i < 3)
		begin : gCarry
			assign carry[i+1] = carry[i] ? sumCarry[16] : sumNoCarry[16];
		end
	end

endmodule

`default_nettype wire

/* fpuMul/fpuMulPack.sv */
`timescale 1ns/1ps
`default_nettype none

module fpuMulPack (
	input logic clock,
	input logic reset,
	mulSumIf.dst sum,
	input fpuPkg::exOpT exOp,
	output logic [63:0] valResult,
	output logic [1:0] exOk
);
	import fpuPkg::*;

	// Q + R, bit k = product weight k+44
	logic [63:0] total;
	logic [fraWidth:0] sigTop;
	logic roundBit;
	logic [fraWidth+1:0] sigRound;
	// two's complement, one bit wider than the stage exponent
	logic [expWidth+1:0] expNorm;
	logic underflow;
	logic overflow;
	fpDouble result;
	exOpT tagFinal;

	csAdd64 finalAdd (
		.a(sum.termQ),
		.b(sum.termR),
		.sum(total)
	);

	always_comb
	begin
		// product of two [1,2) values is in [1,4)
		// bit 61 set means [2,4), take one more shift
		if (total[61])
		begin
			sigTop = total[61:9];
			roundBit = total[8];
		end
		else
		begin
			sigTop = total[60:8];
			roundBit = total[7];
		end

		// half up at the first dropped bit
		sigRound = {1'b0, sigTop} + (fraWidth + 2)'(roundBit);

		// a carry out of rounding leaves the fraction all zero, bump exponent
		expNorm = {sum.exponent[expWidth], sum.exponent}
			+ (expWidth + 2)'(total[61])
			+ (expWidth + 2)'(sigRound[fraWidth+1]);

		// exponent 0 would be a denormal, flushed too
		underflow = expNorm[expWidth+1] || expNorm == '0;
		overflow = !expNorm[expWidth+1] && expNorm >= {2'b00, {expWidth{1'b1}}};

		result.field.sign = sum.sign;
		result.field.exponent = expNorm[expWidth-1:0];
		result.field.fraction = sigRound[fraWidth-1:0];

		if (sum.zero)
		begin
			// zero operand keeps the product sign
			result.field.exponent = '0;
			result.field.fraction = '0;
		end
		else if (underflow)
		begin
			result.bits = '0;
		end
		else if (overflow)
		begin
			// saturate to infinity of the same sign
			result.field.exponent = '1;
			result.field.fraction = '0;
		end
	end

	// result word, edge 4
	always_ff @(posedge clock)
	begin
		if (reset)
			valResult <= '0;
		else if (sum.advance)
			valResult <= result.bits;
	end

	// final tag, compared against the caller's tag
	always_ff @(posedge clock)
	begin
		if (reset)
			tagFinal <= '0;
		else if (sum.advance)
			tagFinal <= sum.tag;
		else
			tagFinal <= '0;
	end

	always_comb
	begin
		if (exOp == '0)
			exOk = exOkReady;
		else if (tagFinal == exOp)
			exOk = exOkOk;
		else
			exOk = exOkHold;
	end

	assert property (@(posedge clock) disable iff (reset)
		exOk != 2'd3);

	// infinity is the only all ones exponent this unit makes
	assert property (@(posedge clock) disable iff (reset)
		!(valResult[62:52] == '1 && valResult[51:0] != '0));

endmodule

`default_nettype wire

/* fpuMul/fpuMulPartials.sv */
`timescale 1ns/1ps
`default_nettype none

module fpuMulPartials (
	input logic clock,
	input logic reset,
	mulOperandIf.dst operand,
	mulSumIf.src sum
);
	import fpuPkg::*;

	/*
	 * significand split in 18 bit limbs
	 *   A = [17:0], B = [35:18], C = [53:36]
	 * XY is limb X of operand a times limb Y of operand b
	 * AA is dropped, AB and BA only keep their top 5x5 corner
	 */

	// stage one inputs, combinational
	logic [35:0] prodAC;
	logic [35:0] prodBB;
	logic [35:0] prodBC;
	logic [35:0] prodCA;
	logic [35:0] prodCB;
	logic [35:0] prodCC;
	logic [9:0] corrAB;
	logic [9:0] corrBA;

	// stage one registers, edge 2
	logic [35:0] regAC;
	logic [35:0] regBB;
	logic [35:0] regBC;
	logic [35:0] regCA;
	logic [35:0] regCB;
	logic [35:0] regCC;
	logic [9:0] regCorrAB;
	logic [9:0] regCorrBA;
	logic sign1;
	logic [expWidth:0] exp1;
	logic zero1;
	exOpT tag1;

	// stage two inputs
	logic [63:0] nextQ;
	logic [63:0] nextR;

	assign sum.advance = operand.advance;

	assign prodAC = operand.sigA[17:0] * operand.sigB[53:36];
	assign prodBB = operand.sigA[35:18] * operand.sigB[35:18];
	assign prodBC = operand.sigA[35:18] * operand.sigB[53:36];
	assign prodCA = operand.sigA[53:36] * operand.sigB[17:0];
	assign prodCB = operand.sigA[53:36] * operand.sigB[35:18];
	assign prodCC = operand.sigA[53:36] * operand.sigB[53:36];

	// top corners of AB and BA, both land at weight 44
	assign corrAB = operand.sigA[17:13] * operand.sigB[35:31];
	assign corrBA = operand.sigA[35:31] * operand.sigB[17:13];

	always_ff @(posedge clock)
	begin
		if (operand.advance)
		begin
			regAC <= prodAC;
			regBB <= prodBB;
			regBC <= prodBC;
			regCA <= prodCA;
			regCB <= prodCB;
			regCC <= prodCC;
			regCorrAB <= corrAB;
			regCorrBA <= corrBA;
			sign1 <= operand.sign;
			exp1 <= operand.expSum;
			zero1 <= operand.zero;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			tag1 <= '0;
		else if (operand.advance)
			tag1 <= operand.tag;
		else
			tag1 <= '0;
	end

	/*
	 * column alignment, bit 0 of each term = product weight 44
	 *   BC, CB at weight 54 -> bit 10
	 *   CC at weight 72 -> bit 28
	 *   BB, AC, CA at weight 36 -> lose their low 8 bits
	 */
	// Q: middle column plus the corner corrections below it
	assign nextQ = {18'h0, regBC, regCorrAB} + {18'h0, regCB, regCorrBA};

	// R: CC and BB side by side, AC and CA added under BB
	assign nextR = {regCC, regBB[35:8]}
		+ {36'h0, regAC[35:8]}
		+ {36'h0, regCA[35:8]};

	always_ff @(posedge clock)
	begin
		if (operand.advance)
		begin
			sum.termQ <= nextQ;
			sum.termR <= nextR;
			sum.sign <= sign1;
			sum.exponent <= exp1;
			sum.zero <= zero1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			sum.tag <= '0;
		else if (operand.advance)
			sum.tag <= tag1;
		else
			sum.tag <= '0;
	end

endmodule

`default_nettype wire

/* fpuMul/fpuMulUnpack.sv */
`timescale 1ns/1ps
`default_nettype none

module fpuMulUnpack (
	input logic clock,
	input logic reset,
	input logic [63:0] valA,
	input logic [63:0] valB,
	input fpuPkg::exOpT exOp,
	mulOperandIf.src operand
);
	import fpuPkg::*;

	fpDouble opA;
	fpDouble opB;
	logic hiddenA;
	logic hiddenB;
	// one extra bit so the top of the sum does not wrap
	logic [expWidth+1:0] expWide;
	logic [expWidth:0] expSat;

	assign opA.bits = valA;
	assign opB.bits = valB;

	// pipeline moves only while a tag is presented
	assign operand.advance = exOp != '0;

	// denormals have no hidden bit and count as zero
	assign hiddenA = opA.field.exponent != '0;
	assign hiddenB = opB.field.exponent != '0;

	// ea + eb - bias, range -1023 .. 3069
	assign expWide = {2'b00, opA.field.exponent} + {2'b00, opB.field.exponent}
		- (expWidth + 2)'(expBias);

	// clamp the high side to 2047, still reads as overflow later
	// low side never goes past -1023 so it fits as is
	always_comb
	begin
		if (!expWide[expWidth+1] && expWide[expWidth])
			expSat = {1'b0, {expWidth{1'b1}}};
		else
			expSat = expWide[expWidth:0];
	end

	// operand fields, held while no tag
	always_ff @(posedge clock)
	begin
		if (operand.advance)
		begin
			operand.sign <= opA.field.sign ^ opB.field.sign;
			operand.expSum <= expSat;
			// top bit stays clear, product fits under bit 106
			operand.sigA <= {1'b0, hiddenA, opA.field.fraction};
			operand.sigB <= {1'b0, hiddenB, opB.field.fraction};
			operand.zero <= !hiddenA || !hiddenB;
		end
	end

	// stage tag
	always_ff @(posedge clock)
	begin
		if (reset)
			operand.tag <= '0;
		else if (operand.advance)
			operand.tag <= exOp;
		else
			operand.tag <= '0;
	end

	// a tagged item downstream always carries a loaded exponent
	assert property (@(posedge clock) disable iff (reset)
		(operand.advance && operand.tag != '0) |-> !$isunknown(operand.expSum));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the multiply unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module fpuMulTb -f tb.f -o fpuMulSim \
	> build.log 2>&1 \
	&& ./obj_dir/fpuMulSim > sim.log 2>&1 \
	|| echo "build or simulation stopped early, see build.log and sim.log"
grep -qx "TB PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* source/fpuMulTop.sv */
`timescale 1ns/1ps
`default_nettype none

module fpuMulTop (
	input logic clock,
	input logic reset,
	input logic [63:0] valA,
	input logic [63:0] valB,
	input logic [1:0] exOp,
	output logic [63:0] valResult,
	output logic [1:0] exOk
);

	// unpack -> partials
	mulOperandIf operandBus ();
	// partials -> pack
	mulSumIf sumBus ();

	// edge 1, field split and exponent sum
	fpuMulUnpack unpack (
		.clock(clock),
		.reset(reset),
		.valA(valA),
		.valB(valB),
		.exOp(exOp),
		.operand(operandBus.src)
	);

	// edges 2 and 3, partial products and reduction
	fpuMulPartials partials (
		.clock(clock),
		.reset(reset),
		.operand(operandBus.dst),
		.sum(sumBus.src)
	);

	// edge 4, final add, round, status
	fpuMulPack pack (
		.clock(clock),
		.reset(reset),
		.sum(sumBus.dst),
		.exOp(exOp),
		.valResult(valResult),
		.exOk(exOk)
	);

endmodule

`default_nettype wire

/* tb.f */
common/fpuPkg.sv
common/fpuStageIf.sv
fpuMul/csAdd64.sv
fpuMul/fpuMulUnpack.sv
fpuMul/fpuMulPartials.sv
fpuMul/fpuMulPack.sv
source/fpuMulTop.sv
verif/fpuMulTb.sv

/* verif/fpuMulTb.sv */
`timescale 1ns/1ps
`default_nettype none

module fpuMulTb;
	import fpuPkg::*;

	localparam int randomCount = 300;
	// directed, alternating and abort items on top of the random ones
	localparam int opCount = randomCount + 30;
	localparam int watchdogCycles = opCount * 12 + 200;

	logic clock;
	logic reset;
	logic [63:0] valA;
	logic [63:0] valB;
	exOpT exOp;
	logic [63:0] valResult;
	logic [1:0] exOk;

	// expected pipeline, one entry per register edge
	exOpT refTag [4];
	logic [63:0] refRes [4];
	logic [1:0] expectOk;
	logic [63:0] expectRes;
	string testName;
	int seedInit;
	int i;

	fpuMulTop UUT (
		.clock(clock),
		.reset(reset),
		.valA(valA),
		.valB(valB),
		.exOp(exOp),
		.valResult(valResult),
		.exOk(exOk)
	);

	always #20 clock = ~clock;

	function automatic logic [63:0] makeDouble(input logic s, input logic [10:0] e,
		input logic [51:0] f);
		fpDouble v;
		v.field.sign = s;
		v.field.exponent = e;
		v.field.fraction = f;
		return v.bits;
	endfunction

	function automatic logic [51:0] randomFraction();
		logic [63:0] raw;
		raw = {$urandom(), $urandom()};
		return raw[51:0];
	endfunction

	// exponents 600..1400, product exponent stays well inside the normal range
	function automatic logic [63:0] randomNormal();
		return makeDouble(1'($urandom()), 11'(600 + $urandom_range(800)), randomFraction());
	endfunction

	// exact 106 bit significand product, normalized, rounded half up
	function automatic logic [63:0] mulModel(input logic [63:0] a, input logic [63:0] b);
		fpDouble x;
		fpDouble y;
		fpDouble r;
		logic [105:0] exact;
		logic [52:0] sigTop;
		logic [53:0] rounded;
		logic roundBit;
		int e;
		x.bits = a;
		y.bits = b;
		r.bits = '0;
		r.field.sign = x.field.sign ^ y.field.sign;
		// denormal or zero operand, signed zero
		if (x.field.exponent == '0 || y.field.exponent == '0)
			return r.bits;
		exact = {53'd0, 1'b1, x.field.fraction} * {53'd0, 1'b1, y.field.fraction};
		e = int'(x.field.exponent) + int'(y.field.exponent) - expBias;
		if (exact[105])
		begin
			sigTop = exact[105:53];
			roundBit = exact[52];
			e = e + 1;
		end
		else
		begin
			sigTop = exact[104:52];
			roundBit = exact[51];
		end
		rounded = {1'b0, sigTop} + {53'd0, roundBit};
		if (rounded[53])
			e = e + 1;
		if (e <= 0)
			r.bits = '0;
		else if (e >= 2047)
		begin
			r.field.exponent = '1;
			r.field.fraction = '0;
		end
		else
		begin
			r.field.exponent = e[10:0];
			r.field.fraction = rounded[51:0];
		end
		return r.bits;
	endfunction

	// zero and infinity exact, normal results within one ulp
	function automatic bit resultClose(input logic [63:0] want, input logic [63:0] got);
		logic [62:0] diff;
		if (want[62:52] == '0 || want[62:52] == '1)
			return got === want;
		if (got[63] !== want[63])
			return 1'b0;
		diff = (got[62:0] > want[62:0]) ? got[62:0] - want[62:0] : want[62:0] - got[62:0];
		return diff <= 63'd1;
	endfunction

	task automatic reportMismatch(input string check, input logic [63:0] want,
		input logic [63:0] got);
		$display("CHECK FAILED %s (%s): expected %h, actual %h", testName, check, want, got);
		$display("TB FAILED");
		$fatal(1, "mismatch on DUT output");
	endtask

	// inputs change 2 ns after the rising edge
	task automatic nextCycle();
		@(posedge clock);
		#2;
	endtask

	task automatic driveInputs(input exOpT tag, input logic [63:0] a, input logic [63:0] b);
		exOp = tag;
		valA = a;
		valB = b;
	endtask

	// present one item, hold until OK, then release
	task automatic runRequest(input exOpT tag, input logic [63:0] a, input logic [63:0] b,
		input int extraHold);
		nextCycle();
		driveInputs(tag, a, b);
		do
			nextCycle();
		while (exOk != exOkOk);
		// one more edge so the OK cycle is sampled
		repeat (extraHold + 1)
			nextCycle();
		driveInputs('0, a, b);
	endtask

	// four stages, data holds while idle, tags drop to zero
	always @(posedge clock)
	begin
		if (reset || exOp == '0)
		begin
			refTag[0] <= '0;
			refTag[1] <= '0;
			refTag[2] <= '0;
			refTag[3] <= '0;
		end
		else
		begin
			refTag[0] <= exOp;
			refTag[1] <= refTag[0];
			refTag[2] <= refTag[1];
			refTag[3] <= refTag[2];
			refRes[0] <= mulModel(valA, valB);
			refRes[1] <= refRes[0];
			refRes[2] <= refRes[1];
			refRes[3] <= refRes[2];
		end
	end

	always_comb
	begin
		if (exOp == '0)
			expectOk = exOkReady;
		else if (refTag[3] == exOp)
			expectOk = exOkOk;
		else
			expectOk = exOkHold;
	end

	assign expectRes = refRes[3];

	// no tag, no work
	assert property (@(posedge clock) disable iff (reset)
		(exOp == '0) |-> (exOk == exOkReady))
		else reportMismatch("ready", 64'(exOkReady), 64'($sampled(exOk)));

	// hold for four edges, OK once the item with this tag is out
	assert property (@(posedge clock) disable iff (reset)
		exOk == expectOk)
		else reportMismatch("status", 64'($sampled(expectOk)), 64'($sampled(exOk)));

	assert property (@(posedge clock) disable iff (reset)
		(exOk == exOkOk) |-> resultClose(expectRes, valResult))
		else reportMismatch("result", $sampled(expectRes), $sampled(valResult));

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		exOp = '0;
		valA = '0;
		valB = '0;
		testName = "reset";
		seedInit = $urandom(32'hfd9971a3);
		repeat (5)
			@(posedge clock);
		#2;
		reset = 1'b0;

		testName = "idle";
		repeat (4)
			nextCycle();

		testName = "latency";
		runRequest(2'd1, randomNormal(), randomNormal(), 0);

		// tags 1..3 in turn
		testName = "random";
		for (i = 0; i < randomCount; i++)
			runRequest(exOpT'(i % 3 + 1), randomNormal(), randomNormal(), 0);

		// denormal counts as zero, sign still xor
		testName = "zero operand";
		runRequest(2'd2, makeDouble(1'b1, '0, randomFraction()), randomNormal(), 0);
		runRequest(2'd3, randomNormal(), makeDouble(1'b0, '0, '0), 0);
		testName = "underflow";
		runRequest(2'd1, makeDouble(1'b0, 11'd100, randomFraction()),
			makeDouble(1'b1, 11'd200, randomFraction()), 0);
		testName = "overflow";
		runRequest(2'd2, makeDouble(1'b1, 11'd1800, randomFraction()),
			makeDouble(1'b0, 11'd1700, randomFraction()), 0);
		// lands exactly on 2047
		runRequest(2'd3, makeDouble(1'b0, 11'd2046, randomFraction()),
			makeDouble(1'b0, 11'd1024, randomFraction()), 0);

		// new item every cycle, tags 1 and 2
		testName = "alternating";
		for (i = 0; i < 12; i++)
		begin
			nextCycle();
			driveInputs(exOpT'(i % 2 + 1), randomNormal(), randomNormal());
		end
		// older tag 1 items drain first, then the held one
		testName = "alternating hold";
		runRequest(2'd1, randomNormal(), randomNormal(), 4);

		// drop the tag with two items in flight
		testName = "abort";
		nextCycle();
		driveInputs(2'd3, randomNormal(), randomNormal());
		repeat (2)
			nextCycle();
		driveInputs('0, valA, valB);
		nextCycle();
		testName = "after abort";
		runRequest(2'd3, randomNormal(), randomNormal(), 0);

		nextCycle();
		$display("TB PASSED");
		$finish;
	end

	initial
	begin
		repeat (watchdogCycles)
			@(posedge clock);
		$display("timeout: run did not finish within %0d cycles", watchdogCycles);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
